// File: Bender.yml
package:
  name: icache

sources:
  - files:
      - rtl/icache_pkg.sv
      - rtl/icache_wr_if.sv
      - rtl/icache_fill.sv
      - rtl/icache_mem.sv
      - rtl/icache_fetch.sv
      - rtl/icache_top.sv
  - target: test
    files:
      - tests/icache_assert.sv
      - tests/icache_tb.sv

// File: rtl/icache_fetch.sv
// icache fetch side
// registers the fetch pc, decides read or skip, picks the word and
// rebuilds branch and jal targets from the stored partial sums

`timescale 1ns/100ps

module icache_fetch (
  input  logic                                 clk_i,
  input  logic                                 network_reset_i,
  input  logic                                 fetch_v_i,
  input  logic                                 fill_busy_i,
  input  logic [icache_pkg::pc_width-1:0]      fetch_pc_i,
  input  logic                                 read_pc_plus4_i,
  input  logic [icache_pkg::pc_width-1:0]      jalr_prediction_i,
  input  icache_pkg::icache_entry_t            rd_entry_i,
  input  logic                                 rd_valid_i,
  output logic                                 rd_v_o,
  output logic [icache_pkg::icache_index_width-1:0] rd_index_o,
  output logic [icache_pkg::instr_width-1:0]   instr_o,
  output logic [icache_pkg::pc_width-1:0]      target_o,
  output logic [icache_pkg::pc_width-1:0]      pc_r_o,
  output logic                                 miss_o,
  output logic                                 branch_imm_sign_o
);
  import icache_pkg::*;

  logic                           accept;
  logic [pc_width-1:0]            pc_r;
  logic [icache_offset_width-1:0] pc_offset;
  logic [icache_tag_width-1:0]    pc_tag;
  logic [instr_width-1:0]         instr;
  logic                           lower_sign;
  logic                           lower_cout;
  logic [branch_high_width-1:0]   pc_high;
  logic [branch_high_width-1:0]   pc_high_out;
  logic [byte_addr_width-1:0]     branch_pc;
  logic [jal_low_width-1:0]       jal_pc;
  logic                           is_jal;
  logic                           is_jalr;

  // fill owns the memory port while it writes
  assign accept = fetch_v_i & ~fill_busy_i;

  always_ff @(posedge clk_i) begin
    if (network_reset_i) begin
      pc_r <= '0;
    end else if (accept) begin
      pc_r <= fetch_pc_i;
    end
  end

  assign pc_offset = pc_r[icache_offset_width-1:0];
  assign pc_tag    = pc_r[pc_width-1 -: icache_tag_width];

  // skip the read when pc+4 stays inside the held block
  assign rd_v_o     = accept & (~read_pc_plus4_i | (&pc_offset));
  assign rd_index_o = fetch_pc_i[icache_offset_width +: icache_index_width];

  // word select, restore the dropped 2'b11
  assign instr      = {rd_entry_i.instr[pc_offset], 2'b11};
  assign lower_sign = rd_entry_i.lower_sign[pc_offset];
  assign lower_cout = rd_entry_i.lower_cout[pc_offset];

  assign is_jal  = instr[6:0] == op_jal;
  assign is_jalr = instr[6:0] == op_jalr;

  // pc bits above the branch adder
  assign pc_high = pc_r[branch_low_width-2 +: branch_high_width];

  // carry fix-up of the upper part
  // sign == cout keeps it, 0/1 adds one, 1/0 takes one off
  always_comb begin
    if (lower_sign == lower_cout) begin
      pc_high_out = pc_high;
    end else if (lower_cout) begin
      pc_high_out = pc_high + 1'b1;
    end else begin
      pc_high_out = pc_high - 1'b1;
    end
  end

  // byte addresses
  assign branch_pc = {pc_high_out, bimm_extract(instr)};
  // jal adder already covers the whole byte address
  assign jal_pc = jimm_extract(instr);

  always_comb begin
    if (is_jal) begin
      target_o = jal_pc[2 +: pc_width];
    end else if (is_jalr) begin
      target_o = jalr_prediction_i;
    end else begin
      target_o = branch_pc[2 +: pc_width];
    end
  end

  assign instr_o           = instr;
  assign pc_r_o            = pc_r;
  assign branch_imm_sign_o = lower_sign;

  // invalid line or foreign tag
  assign miss_o = ~rd_valid_i | (rd_entry_i.tag != pc_tag);

endmodule

// File: rtl/icache_fill.sv
// icache fill side
// wishbone classic write slave that pre-computes the low part of branch
// and jal targets, buffers three words and writes whole lines on the fourth

`timescale 1ns/100ps

module icache_fill (
  input  logic                               clk_i,
  input  logic                               network_reset_i,
  input  logic                               wb_cyc_i,
  input  logic                               wb_stb_i,
  input  logic                               wb_we_i,
  input  logic [icache_pkg::pc_width-1:0]    wb_adr_i,
  input  logic [icache_pkg::instr_width-1:0] wb_dat_i,
  output logic                               wb_ack_o,
  icache_wr_if.fill                          wr
);
  import icache_pkg::*;

  logic                           wb_req;
  logic                           ack_r;
  logic                           accept;
  logic [icache_tag_width-1:0]    w_tag;
  logic [icache_index_width-1:0]  w_index;
  logic [icache_offset_width-1:0] w_block_offset;
  logic [icache_offset_width-1:0] write_count_r;
  logic                           is_branch;
  logic                           is_jal;
  logic [branch_low_width-1:0]    b_imm;
  logic [branch_low_width-1:0]    b_pc;
  logic [branch_low_width-1:0]    b_sum;
  logic                           b_cout;
  logic [jal_low_width-1:0]       j_imm;
  logic [jal_low_width-1:0]       j_pc;
  logic [jal_low_width-1:0]       j_sum;
  logic                           j_cout;
  logic [instr_width-1:0]         inj_instr;
  logic [stored_instr_width-1:0]  dropped_instr;
  logic                           imm_sign;
  logic                           pc_lower_cout;

  logic [icache_block_words-2:0]                         sign_buf_r;
  logic [icache_block_words-2:0]                         cout_buf_r;
  logic [icache_block_words-2:0][stored_instr_width-1:0] instr_buf_r;

  // wishbone handshake where reads get an empty ack
  assign wb_req = wb_cyc_i & wb_stb_i & wb_we_i;
  assign accept = wb_req & ack_r;
  assign wb_ack_o = ack_r;

  always_ff @(posedge clk_i) begin
    if (network_reset_i) begin
      ack_r <= 1'b0;
    end else begin
      // one-cycle pulse per strobe
      ack_r <= wb_cyc_i & wb_stb_i & ~ack_r;
    end
  end

  assign {w_tag, w_index, w_block_offset} = wb_adr_i;

  // opcode decode of the incoming word
  assign is_branch = wb_dat_i[6:0] == op_branch;
  assign is_jal    = wb_dat_i[6:0] == op_jal;

  // low target adders on the byte address
  assign b_imm = bimm_extract(wb_dat_i);
  assign b_pc  = branch_low_width'({wb_adr_i, 2'b00});
  assign j_imm = jimm_extract(wb_dat_i);
  assign j_pc  = jal_low_width'({wb_adr_i, 2'b00});

  assign {b_cout, b_sum} = {1'b0, b_imm} + {1'b0, b_pc};
  assign {j_cout, j_sum} = {1'b0, j_imm} + {1'b0, j_pc};

  // partial sum goes back into the immediate field
  // bit 0 is implied
  always_comb begin
    inj_instr = wb_dat_i;
    if (is_branch) begin
      inj_instr[31]    = b_sum[12];
      inj_instr[7]     = b_sum[11];
      inj_instr[30:25] = b_sum[10:5];
      inj_instr[11:8]  = b_sum[4:1];
    end else if (is_jal) begin
      inj_instr[31]    = j_sum[20];
      inj_instr[19:12] = j_sum[19:12];
      inj_instr[20]    = j_sum[11];
      inj_instr[30:21] = j_sum[10:1];
    end
  end

  // low two bits are always 2'b11
  assign dropped_instr = inj_instr[instr_width-1:2];

  // sign and carry only mean something for control words
  // both formats keep the immediate sign in the top bit
  assign imm_sign      = (is_branch | is_jal) & wb_dat_i[instr_width-1];
  assign pc_lower_cout = is_branch ? b_cout : (is_jal & j_cout);

  // block word counter
  always_ff @(posedge clk_i) begin
    if (network_reset_i) begin
      write_count_r <= '0;
    end else if (accept) begin
      write_count_r <= write_count_r + 1'b1;
    end
  end

  // first three words wait here
  always_ff @(posedge clk_i) begin
    if (accept & ~(&write_count_r)) begin
      sign_buf_r[write_count_r]  <= imm_sign;
      cout_buf_r[write_count_r]  <= pc_lower_cout;
      instr_buf_r[write_count_r] <= dropped_instr;
    end
  end

  // fourth word completes the line
  assign wr.wr_v     = accept & (&write_count_r);
  assign wr.wr_index = w_index;
  assign wr.wr_tag   = w_tag;
  assign wr.wr_entry = '{
    lower_sign: {imm_sign, sign_buf_r},
    lower_cout: {pc_lower_cout, cout_buf_r},
    tag:        wr.wr_tag,
    instr:      {dropped_instr, instr_buf_r}
  };

endmodule

// File: rtl/icache_mem.sv
// icache line storage
// single-port synchronous line array with a valid flag per line,
// read data holds between reads so a skipped read reuses the block

`timescale 1ns/100ps

module icache_mem (
  input  logic                                  clk_i,
  input  logic                                  network_reset_i,
  input  logic                                  rd_v_i,
  input  logic [icache_pkg::icache_index_width-1:0] rd_index_i,
  icache_wr_if.mem                              wr,
  output icache_pkg::icache_entry_t             rd_entry_o,
  output logic                                  rd_valid_o
);
  import icache_pkg::*;

  icache_entry_t           lines_r [icache_lines];
  logic [icache_lines-1:0] valid_r;

  // line array, write owns the port
  always_ff @(posedge clk_i) begin
    if (wr.wr_v) begin
      lines_r[wr.wr_index] <= wr.wr_entry;
    end else if (rd_v_i) begin
      rd_entry_o <= lines_r[rd_index_i];
    end
  end

  // valid flags and the registered flag of the last read
  always_ff @(posedge clk_i) begin
    if (network_reset_i) begin
      valid_r    <= '0;
      rd_valid_o <= 1'b0;
    end else begin
      if (wr.wr_v) begin
        valid_r[wr.wr_index] <= 1'b1;
      end else if (rd_v_i) begin
        rd_valid_o <= valid_r[rd_index_i];
      end
    end
  end

endmodule

// File: rtl/icache_pkg.sv
// icache package
// cache geometry, rv32 opcodes, line entry format and the immediate
// extraction helpers shared by the fill and fetch sides

package icache_pkg;

  // geometry
  localparam int icache_tag_width    = 8;
  localparam int icache_entries      = 64;
  localparam int icache_block_words  = 4;
  localparam int icache_lines        = icache_entries / icache_block_words;
  localparam int icache_offset_width = $clog2(icache_block_words);
  localparam int icache_index_width  = $clog2(icache_lines);
  localparam int pc_width = icache_tag_width + icache_index_width + icache_offset_width;

  // instruction widths
  localparam int instr_width        = 32;
  localparam int stored_instr_width = instr_width - 2;
  localparam int bimm_width         = 12;
  localparam int jimm_width         = 20;

  // partial target adders, byte addressed
  localparam int byte_addr_width   = pc_width + 2;
  localparam int branch_low_width  = bimm_width + 1;
  localparam int jal_low_width     = jimm_width + 1;
  localparam int branch_high_width = byte_addr_width - branch_low_width;

  // rv32 major opcodes
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_jal    = 7'b1101111;
  localparam logic [6:0] op_jalr   = 7'b1100111;

  // one cache line, word i sits at index i of each field
  typedef struct packed {
    logic [icache_block_words-1:0]                         lower_sign;
    logic [icache_block_words-1:0]                         lower_cout;
    logic [icache_tag_width-1:0]                           tag;
    logic [icache_block_words-1:0][stored_instr_width-1:0] instr;
  } icache_entry_t;

  // 13-bit B-type immediate, bit 0 always zero
  function automatic logic [branch_low_width-1:0] bimm_extract(
    input logic [instr_width-1:0] instr
  );
    return {instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  endfunction

  // 21-bit J-type immediate, bit 0 always zero
  function automatic logic [jal_low_width-1:0] jimm_extract(
    input logic [instr_width-1:0] instr
  );
    return {instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
  endfunction

endpackage

// File: rtl/icache_top.sv
// icache top level
// fill port on wishbone, fetch port answering one cycle after the request,
// both sharing one single-port line store

`timescale 1ns/100ps

module icache_top (
  input  logic                               clk_i,
  input  logic                               network_reset_i,
  // wishbone fill port
  input  logic                               wb_cyc_i,
  input  logic                               wb_stb_i,
  input  logic                               wb_we_i,
  input  logic [icache_pkg::pc_width-1:0]    wb_adr_i,
  input  logic [icache_pkg::instr_width-1:0] wb_dat_i,
  output logic                               wb_ack_o,
  // fetch port
  input  logic                               fetch_v_i,
  input  logic [icache_pkg::pc_width-1:0]    fetch_pc_i,
  input  logic                               read_pc_plus4_i,
  input  logic [icache_pkg::pc_width-1:0]    jalr_prediction_i,
  output logic [icache_pkg::instr_width-1:0] instr_o,
  output logic [icache_pkg::pc_width-1:0]    target_o,
  output logic [icache_pkg::pc_width-1:0]    pc_r_o,
  output logic                               miss_o,
  output logic                               branch_imm_sign_o
);
  import icache_pkg::*;

  logic                          fill_busy;
  logic                          rd_v;
  logic [icache_index_width-1:0] rd_index;
  icache_entry_t                 rd_entry;
  logic                          rd_valid;

  icache_wr_if wr_if ();

  // write request blocks fetches
  assign fill_busy = wb_cyc_i & wb_stb_i & wb_we_i;

  icache_fill fill0 (
    .clk_i           (clk_i),
    .network_reset_i (network_reset_i),
    .wb_cyc_i        (wb_cyc_i),
    .wb_stb_i        (wb_stb_i),
    .wb_we_i         (wb_we_i),
    .wb_adr_i        (wb_adr_i),
    .wb_dat_i        (wb_dat_i),
    .wb_ack_o        (wb_ack_o),
    .wr              (wr_if.fill)
  );

  icache_mem mem0 (
    .clk_i           (clk_i),
    .network_reset_i (network_reset_i),
    .rd_v_i          (rd_v),
    .rd_index_i      (rd_index),
    .wr              (wr_if.mem),
    .rd_entry_o      (rd_entry),
    .rd_valid_o      (rd_valid)
  );

  icache_fetch fetch0 (
    .clk_i             (clk_i),
    .network_reset_i   (network_reset_i),
    .fetch_v_i         (fetch_v_i),
    .fill_busy_i       (fill_busy),
    .fetch_pc_i        (fetch_pc_i),
    .read_pc_plus4_i   (read_pc_plus4_i),
    .jalr_prediction_i (jalr_prediction_i),
    .rd_entry_i        (rd_entry),
    .rd_valid_i        (rd_valid),
    .rd_v_o            (rd_v),
    .rd_index_o        (rd_index),
    .instr_o           (instr_o),
    .target_o          (target_o),
    .pc_r_o            (pc_r_o),
    .miss_o            (miss_o),
    .branch_imm_sign_o (branch_imm_sign_o)
  );

endmodule

// File: rtl/icache_wr_if.sv
// icache line write channel
// carries one complete line from the fill side into the line storage

`timescale 1ns/100ps

interface icache_wr_if;
  import icache_pkg::*;

  // single-cycle write strobe that the storage always takes
  logic                          wr_v;
  logic [icache_index_width-1:0] wr_index;
  logic [icache_tag_width-1:0]   wr_tag;
  icache_entry_t                 wr_entry;

  modport fill (output wr_v, output wr_index, output wr_tag, output wr_entry);
  modport mem  (input wr_v, input wr_index, input wr_tag, input wr_entry);

endinterface

// File: tests/icache_assert.sv
// fill side checker
// wishbone acknowledge shape and block word ordering on the fill port

`timescale 1ns/100ps

module icache_assert (
  input logic                                       clk_i,
  input logic                                       network_reset_i,
  input logic                                       strobe_i,
  input logic                                       wb_ack_i,
  input logic                                       accept_i,
  input logic [icache_pkg::icache_offset_width-1:0] block_offset_i,
  input logic [icache_pkg::icache_offset_width-1:0] write_count_i
);

  // failed assertions so far
  int fail_count = 0;

  // words come in block order
  word_order: assert property (@(posedge clk_i) disable iff (network_reset_i)
    accept_i |-> block_offset_i == write_count_i)
    else begin
      fail_count++;
      $error("fill offset %0d differs from word counter %0d", block_offset_i, write_count_i);
    end

  // single-cycle ack
  ack_pulse: assert property (@(posedge clk_i) disable iff (network_reset_i)
    wb_ack_i |=> !wb_ack_i)
    else begin
      fail_count++;
      $error("wishbone ack held longer than one cycle");
    end

  // ack only while the strobe is still held
  ack_with_strobe: assert property (@(posedge clk_i) disable iff (network_reset_i)
    wb_ack_i |-> strobe_i)
    else begin
      fail_count++;
      $error("wishbone ack without a strobe");
    end

endmodule

bind icache_fill icache_assert assert0 (
  .clk_i           (clk_i),
  .network_reset_i (network_reset_i),
  .strobe_i        (wb_cyc_i & wb_stb_i),
  .wb_ack_i        (wb_ack_o),
  .accept_i        (accept),
  .block_offset_i  (w_block_offset),
  .write_count_i   (write_count_r)
);

// File: tests/icache_tb.sv
// icache testbench
// fills lines over wishbone from a word table, then fetches from a table of
// pcs and compares instruction, target, sign and miss with values worked
// out from the rv32 immediate rules

`timescale 1ns/100ps

module icache_tb;
  import icache_pkg::*;

  // word kinds of the shadow program
  localparam int kind_alu    = 0;
  localparam int kind_branch = 1;
  localparam int kind_jal    = 2;
  localparam int kind_jalr   = 3;

  typedef struct {
    string                  name;
    logic [pc_width-1:0]    adr;
    logic [instr_width-1:0] dat;
  } fill_row_t;

  typedef struct {
    string                  name;
    logic [pc_width-1:0]    pc;
    logic                   hint;
    logic [pc_width-1:0]    pred;
    logic                   exp_miss;
    int                     kind;
    logic [instr_width-1:0] exp_instr;
    logic [pc_width-1:0]    exp_target;
    logic                   exp_sign;
  } fetch_row_t;

  logic                   clk;
  logic                   rst;
  logic                   wb_cyc;
  logic                   wb_stb;
  logic                   wb_we;
  logic [pc_width-1:0]    wb_adr;
  logic [instr_width-1:0] wb_dat;
  logic                   wb_ack;
  logic                   fetch_v;
  logic [pc_width-1:0]    fetch_pc;
  logic                   pc4;
  logic [pc_width-1:0]    jalr_pred;
  logic [instr_width-1:0] instr;
  logic [pc_width-1:0]    target;
  logic [pc_width-1:0]    pc_r;
  logic                   miss;
  logic                   sign;

  fill_row_t              fill_tab[$];
  fetch_row_t             fetch_tab[$];
  logic [instr_width-1:0] shadow_word[int];
  int                     shadow_kind[int];
  int                     shadow_imm[int];
  int                     errors = 0;
  int                     checks = 0;
  int                     assert_fails = 0;
  int                     cycles = 0;
  int                     cycle_limit = 0;
  int                     pre_rows = 0;

  icache_top dut0 (
    .clk_i             (clk),
    .network_reset_i   (rst),
    .wb_cyc_i          (wb_cyc),
    .wb_stb_i          (wb_stb),
    .wb_we_i           (wb_we),
    .wb_adr_i          (wb_adr),
    .wb_dat_i          (wb_dat),
    .wb_ack_o          (wb_ack),
    .fetch_v_i         (fetch_v),
    .fetch_pc_i        (fetch_pc),
    .read_pc_plus4_i   (pc4),
    .jalr_prediction_i (jalr_pred),
    .instr_o           (instr),
    .target_o          (target),
    .pc_r_o            (pc_r),
    .miss_o            (miss),
    .branch_imm_sign_o (sign)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // run limit from the table lengths
  always @(posedge clk) begin
    cycles++;
    if (cycle_limit > 0 && cycles > cycle_limit) begin
      $display("Timeout: run did not finish within %0d cycles", cycle_limit);
      $display("Checks failed");
      $finish;
    end
  end

  // rv32 encoders with rs1 = x1 and rs2 = x2
  function automatic logic [31:0] branch_word(input int imm);
    logic [12:0] b;
    b = 13'(imm);
    return {b[12], b[10:5], 5'd2, 5'd1, 3'b000, b[4:1], b[11], op_branch};
  endfunction

  function automatic logic [31:0] jal_word(input int imm);
    logic [20:0] j;
    j = 21'(imm);
    return {j[20], j[10:1], j[11], j[19:12], 5'd1, op_jal};
  endfunction

  function automatic logic [31:0] jalr_word();
    return {12'h010, 5'd1, 3'b000, 5'd0, op_jalr};
  endfunction

  // random addi as filler
  function automatic logic [31:0] alu_word();
    logic [31:0] r;
    r = $urandom;
    return {r[31:15], 3'b000, r[11:7], 7'b0010011};
  endfunction

  // word pc * 4 + imm as a word address modulo the pc range
  function automatic logic [pc_width-1:0] target_of(input logic [pc_width-1:0] pc,
                                                    input int imm);
    logic [31:0] byte_addr;
    byte_addr = 32'(pc) * 4 + imm;
    return byte_addr[pc_width+1:2];
  endfunction

  task automatic check_value(input string name, input string field,
                             input logic [31:0] expected, input logic [31:0] actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("Error %s, %s: expected %h, actual %h", name, field, expected, actual);
    end
  endtask

  task automatic place_word(input string name, input int adr, input int kind, input int imm);
    logic [31:0] word;
    case (kind)
      kind_branch: word = branch_word(imm);
      kind_jal:    word = jal_word(imm);
      kind_jalr:   word = jalr_word();
      default:     word = alu_word();
    endcase
    shadow_word[adr] = word;
    shadow_kind[adr] = kind;
    shadow_imm[adr]  = imm;
    fill_tab.push_back('{name, pc_width'(adr), word});
  endtask

  task automatic add_fetch(input string name, input int pc, input logic hint, input logic miss_exp);
    fetch_row_t row;
    row.name       = name;
    row.pc         = pc_width'(pc);
    row.hint       = hint;
    row.pred       = ~row.pc;
    row.exp_miss   = miss_exp;
    row.kind       = shadow_kind.exists(pc) ? shadow_kind[pc] : kind_alu;
    row.exp_instr  = shadow_word.exists(pc) ? shadow_word[pc] : '0;
    row.exp_sign   = 1'b0;
    // jalr follows the prediction input
    row.exp_target = row.pred;
    if (row.kind == kind_branch || row.kind == kind_jal) begin
      row.exp_target = target_of(row.pc, shadow_imm[pc]);
      row.exp_sign   = shadow_imm[pc] < 0;
    end
    fetch_tab.push_back(row);
  endtask

  task automatic build_tables();
    int base;
    // empty cache right after reset
    add_fetch("reset_miss", 'h0123, 1'b0, 1'b1);
    add_fetch("reset_miss_filled_later", 'h0010, 1'b0, 1'b1);
    pre_rows = fetch_tab.size();
    // plain alu words at index 4 and tag 0
    for (base = 'h0010; base < 'h0014; base++) begin
      place_word("alu_block", base, kind_alu, 0);
    end
    // forward cases around the low field end at byte 0x1fff
    place_word("branch_fwd", 'h07fc, kind_branch, 8);
    place_word("branch_fwd", 'h07fd, kind_branch, 16);
    place_word("branch_fwd", 'h07fe, kind_branch, -20);
    place_word("branch_fwd", 'h07ff, kind_jal, 2048);
    // backward cases from the low field start at byte 0x2000
    place_word("branch_back", 'h0800, kind_branch, -8);
    place_word("branch_back", 'h0801, kind_jal, -64);
    place_word("branch_back", 'h0802, kind_jalr, 0);
    place_word("branch_back", 'h0803, kind_alu, 0);
    // targets that wrap around the pc range
    place_word("wrap_block", 'h0004, kind_alu, 0);
    place_word("wrap_block", 'h0005, kind_branch, -4096);
    place_word("wrap_block", 'h0006, kind_jal, 1048574);
    place_word("wrap_block", 'h0007, kind_alu, 0);
    for (base = 'h0010; base < 'h0014; base++) begin
      add_fetch("alu_hit", base, 1'b0, 1'b0);
    end
    add_fetch("alu_pc4", 'h0010, 1'b0, 1'b0);
    for (base = 'h0011; base < 'h0014; base++) begin
      add_fetch("alu_pc4", base, 1'b1, 1'b0);
    end
    // same index with another tag
    add_fetch("tag_miss", 'h0050, 1'b0, 1'b1);
    add_fetch("tag_miss", 'h0840, 1'b0, 1'b1);
    for (base = 'h07fc; base < 'h0804; base++) begin
      add_fetch("control_hit", base, 1'b0, 1'b0);
    end
    add_fetch("wrap_pc4", 'h0004, 1'b0, 1'b0);
    for (base = 'h0005; base < 'h0008; base++) begin
      add_fetch("wrap_pc4", base, 1'b1, 1'b0);
    end
    // last word of a block forces a read even with the hint high
    add_fetch("control_pc4", 'h07fc, 1'b0, 1'b0);
    for (base = 'h07fd; base < 'h0802; base++) begin
      add_fetch("control_pc4", base, 1'b1, 1'b0);
    end
  endtask

  task automatic write_word(input fill_row_t row);
    int wait_cycles;
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we  = 1'b1;
    wb_adr = row.adr;
    wb_dat = row.dat;
    wait_cycles = 0;
    do begin
      @(posedge clk);
      #1;
      wait_cycles++;
    end while (wb_ack !== 1'b1);
    check_value(row.name, "ack latency", 1, wait_cycles);
    // word is taken on this edge and the pulse ends with it
    @(posedge clk);
    #1;
    check_value(row.name, "ack after pulse", 0, wb_ack);
  endtask

  task automatic run_fetch(input fetch_row_t row);
    fetch_v   = 1'b1;
    fetch_pc  = row.pc;
    pc4       = row.hint;
    jalr_pred = row.pred;
    @(posedge clk);
    #1;
    fetch_v = 1'b0;
    check_value(row.name, "pc_r", row.pc, pc_r);
    check_value(row.name, "miss", row.exp_miss, miss);
    if (!row.exp_miss) begin
      check_value(row.name, "sign", row.exp_sign, sign);
      if (row.kind == kind_alu) begin
        check_value(row.name, "instr", row.exp_instr, instr);
      end else begin
        check_value(row.name, "target", row.exp_target, target);
      end
    end
  endtask

  initial begin
    void'($urandom(32'h614c_4c31));
    rst       = 1'b1;
    wb_cyc    = 1'b0;
    wb_stb    = 1'b0;
    wb_we     = 1'b0;
    wb_adr    = '0;
    wb_dat    = '0;
    fetch_v   = 1'b0;
    fetch_pc  = '0;
    pc4       = 1'b0;
    jalr_pred = '0;
    build_tables();
    cycle_limit = 40 * (fill_tab.size() + fetch_tab.size()) + 10;
    repeat (10) @(posedge clk);
    #1;
    rst = 1'b0;
    check_value("reset", "wb_ack", 0, wb_ack);
    for (int i = 0; i < pre_rows; i++) begin
      run_fetch(fetch_tab[i]);
    end
    for (int i = 0; i < fill_tab.size(); i++) begin
      write_word(fill_tab[i]);
    end
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
    for (int i = pre_rows; i < fetch_tab.size(); i++) begin
      run_fetch(fetch_tab[i]);
    end
    // failures of the bound fill checker
    assert_fails = dut0.fill0.assert0.fail_count;
    $display("Done: %0d checks, %0d errors, %0d assertion failures", checks, errors,
             assert_fails);
    if (errors == 0 && assert_fails == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// File: vlog.f
rtl/icache_pkg.sv
rtl/icache_wr_if.sv
rtl/icache_fill.sv
rtl/icache_mem.sv
rtl/icache_fetch.sv
rtl/icache_top.sv
tests/icache_assert.sv
tests/icache_tb.sv
